//--- design/ccc_consts.svh
// CCC command codes, reserved address, GET byte counts and ENEC/DISEC bit positions
`ifndef CCC_CONSTS_SVH
`define CCC_CONSTS_SVH

// Broadcast codes have bit 7 clear, direct codes have it set
`define CCC_BCAST_ENEC      8'h00
`define CCC_DIRECT_ENEC     8'h80
`define CCC_BCAST_DISEC     8'h01
`define CCC_DIRECT_DISEC    8'h81
`define CCC_BCAST_RSTDAA    8'h06
`define CCC_BCAST_SETMWL    8'h09
`define CCC_DIRECT_SETMWL   8'h89
`define CCC_BCAST_SETMRL    8'h0A
`define CCC_DIRECT_SETMRL   8'h8A
`define CCC_DIRECT_GETMWL   8'h8B
`define CCC_DIRECT_GETPID   8'h8D
`define CCC_DIRECT_GETBCR   8'h8E
`define CCC_DIRECT_GETDCR   8'h8F

// Broadcast address, also used to hand over to the next CCC
`define I3C_RSVD_ADDR       7'h7E

// GET response lengths in bytes
`define GET_LEN_BCR         3'd1
`define GET_LEN_MWL         3'd2
`define GET_LEN_PID         3'd6

// Event bits inside an ENEC/DISEC byte
`define EC_IBI_BIT          0
`define EC_CRR_BIT          1
`define EC_HJ_BIT           3

`endif

//--- design/ccc_pkg.sv
// CCC level types: field widths, sequencer states, SET events and configuration outputs
package ccc_pkg;

  typedef logic [7:0] ccc_code_t;
  typedef logic [6:0] i3c_addr_t;
  typedef logic [7:0] ccc_byte_t;
  // GET bytes still to be sent
  typedef logic [2:0] get_cnt_t;

  typedef enum logic [3:0] {
    st_wait_ccc,
    st_rx_tbit,
    st_rx_byte,
    st_rx_byte_tbit,
    st_rx_addr,
    st_tx_ack,
    st_rx_data,
    st_rx_data_tbit,
    st_tx_data,
    st_tx_data_tbit,
    st_wait_bus,
    st_next_ccc,
    st_done_ccc
  } ccc_state_e;

  typedef struct packed {
    i3c_addr_t sta_addr;
    logic      sta_valid;
    i3c_addr_t dyn_addr;
    logic      dyn_valid;
  } target_addr_t;

  // Sequencer to SET handler, all flags are one-cycle pulses
  typedef struct packed {
    ccc_code_t code;
    logic      cmd_tbit;
    logic      data_valid;
    ccc_byte_t data;
    logic      frame_start;
  } ccc_rx_evt_t;

  typedef struct packed {
    logic        set_mwl;
    logic [15:0] mwl;
    logic        set_mrl;
    logic [15:0] mrl;
    logic [2:0]  enec;
    logic [2:0]  disec;
    logic        rstdaa;
  } ccc_cfg_t;

endpackage

//--- design/ccc_bus_pkg.sv
// Bus engine request, response and bus condition structs
package ccc_bus_pkg;

  typedef logic [7:0] bus_data_t;

  // One of req_byte or req_bit at a time, held until done
  typedef struct packed {
    logic      req_byte;
    logic      req_bit;
    bus_data_t value;
    logic      sel_od_pp;
  } bus_tx_req_t;

  typedef struct packed {
    logic req_bit;
    logic req_byte;
  } bus_rx_req_t;

  // done is a single-cycle pulse, data valid with it
  typedef struct packed {
    logic      done;
    bus_data_t data;
  } bus_rx_rsp_t;

  typedef struct packed {
    logic rstart_det;
    logic stop_det;
  } bus_evt_t;

endpackage

//--- design/ccc_sequencer.sv
// CCC frame FSM with command capture, direct address match and bus engine requests
`timescale 1ns/10ps
`include "ccc_consts.svh"

module ccc_sequencer (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  ccc_pkg::ccc_code_t       ccc_i,
  input  logic                     ccc_valid_i,
  input  ccc_bus_pkg::bus_evt_t    bus_evt_i,
  input  ccc_bus_pkg::bus_rx_rsp_t bus_rx_i,
  input  logic                     bus_tx_done_i,
  input  ccc_pkg::target_addr_t    target_addr_i,
  input  ccc_pkg::ccc_byte_t       get_byte_i,
  input  logic                     get_last_i,
  output ccc_bus_pkg::bus_rx_req_t bus_rx_req_o,
  output ccc_bus_pkg::bus_tx_req_t bus_tx_req_o,
  output logic                     get_load_o,
  output logic                     get_next_o,
  output ccc_pkg::ccc_code_t       ccc_code_o,
  output ccc_pkg::ccc_rx_evt_t     rx_evt_o,
  output logic                     done_o,
  output logic                     next_ccc_o
);
  import ccc_pkg::*;

  ccc_state_e state_q;
  ccc_state_e state_d;
  ccc_code_t  code_q;
  i3c_addr_t  addr_q;
  logic       rnw_q;
  ccc_byte_t  rx_data_q;
  logic       last_sent_q;
  logic       is_direct;
  logic       addr_rsvd;
  logic       addr_ours;
  logic       addr_ack;
  logic       ccc_accept;
  logic       addr_done;

  // Bit 7 of the code marks a direct CCC
  assign is_direct  = code_q[7];
  assign ccc_accept = (state_q == st_wait_ccc) && ccc_valid_i;
  assign addr_done  = (state_q == st_rx_addr) && bus_rx_i.done;
  assign addr_rsvd  = (addr_q == `I3C_RSVD_ADDR);
  assign addr_ours  = (target_addr_i.sta_valid && (addr_q == target_addr_i.sta_addr)) ||
                      (target_addr_i.dyn_valid && (addr_q == target_addr_i.dyn_addr));
  assign addr_ack   = addr_rsvd || addr_ours;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      code_q      <= '0;
      addr_q      <= '0;
      rnw_q       <= 1'b0;
      last_sent_q <= 1'b0;
    end else begin
      if (ccc_accept) begin
        code_q <= ccc_i;
        // No direct address yet in a new frame
        addr_q <= '0;
      end
      if (addr_done) begin
        addr_q <= bus_rx_i.data[7:1];
        rnw_q  <= bus_rx_i.data[0];
      end
      // Remember whether the byte just sent closes the response
      if ((state_q == st_tx_data) && bus_tx_done_i) begin
        last_sent_q <= get_last_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == st_rx_data) && bus_rx_i.done) begin
      rx_data_q <= bus_rx_i.data;
    end
  end

  // Stop ends the CCC from any state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_wait_ccc;
    end else if (bus_evt_i.stop_det) begin
      state_q <= st_done_ccc;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_wait_ccc:     if (ccc_valid_i) state_d = st_rx_tbit;
      st_rx_tbit:      if (bus_rx_i.done) state_d = is_direct ? st_rx_byte : st_rx_data;
      st_rx_byte: begin
        if (bus_evt_i.rstart_det) state_d = st_rx_addr;
        else if (bus_rx_i.done) state_d = st_rx_byte_tbit;
      end
      st_rx_byte_tbit: if (bus_rx_i.done) state_d = st_rx_byte;
      st_rx_addr:      if (bus_rx_i.done) state_d = st_tx_ack;
      st_tx_ack: begin
        if (bus_tx_done_i) begin
          if (addr_rsvd) state_d = st_next_ccc;
          else if (addr_ours && rnw_q) state_d = st_tx_data;
          else if (addr_ours) state_d = st_rx_data;
          else state_d = st_wait_bus;
        end
      end
      st_rx_data: begin
        if (bus_evt_i.rstart_det) state_d = st_rx_addr;
        else if (bus_rx_i.done) state_d = st_rx_data_tbit;
      end
      st_rx_data_tbit: if (bus_rx_i.done) state_d = st_rx_data;
      st_tx_data: begin
        if (bus_evt_i.rstart_det) state_d = st_rx_addr;
        else if (bus_tx_done_i) state_d = st_tx_data_tbit;
      end
      st_tx_data_tbit: if (bus_tx_done_i) state_d = last_sent_q ? st_wait_bus : st_tx_data;
      st_wait_bus:     if (bus_evt_i.rstart_det) state_d = st_rx_addr;
      st_next_ccc:     state_d = st_wait_ccc;
      st_done_ccc:     state_d = st_wait_ccc;
      default:         state_d = st_wait_ccc;
    endcase
  end

  always_comb begin
    bus_rx_req_o = '0;
    bus_tx_req_o = '0;
    case (state_q)
      st_rx_tbit, st_rx_byte_tbit, st_rx_data_tbit: bus_rx_req_o.req_bit = 1'b1;
      st_rx_byte, st_rx_addr, st_rx_data:           bus_rx_req_o.req_byte = 1'b1;
      // ACK is driven open drain, 0 acknowledges
      st_tx_ack: begin
        bus_tx_req_o.req_bit = 1'b1;
        bus_tx_req_o.value   = {7'd0, !addr_ack};
      end
      st_tx_data: begin
        bus_tx_req_o.req_byte  = 1'b1;
        bus_tx_req_o.value     = get_byte_i;
        bus_tx_req_o.sel_od_pp = 1'b1;
      end
      // T-bit 1 means more bytes follow
      st_tx_data_tbit: begin
        bus_tx_req_o.req_bit   = 1'b1;
        bus_tx_req_o.value     = {7'd0, !last_sent_q};
        bus_tx_req_o.sel_od_pp = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign get_load_o = (state_q == st_tx_ack);
  assign get_next_o = (state_q == st_tx_data) && bus_tx_done_i;
  assign ccc_code_o = code_q;
  assign done_o     = (state_q == st_done_ccc);
  assign next_ccc_o = (state_q == st_next_ccc);

  // SET data from a frame addressed to 7'h7E is dropped
  assign rx_evt_o.code        = code_q;
  assign rx_evt_o.cmd_tbit    = (state_q == st_rx_tbit) && bus_rx_i.done;
  assign rx_evt_o.data_valid  = (state_q == st_rx_data_tbit) && bus_rx_i.done && !addr_rsvd;
  assign rx_evt_o.data        = rx_data_q;
  assign rx_evt_o.frame_start = ccc_accept || addr_done;

endmodule

//--- design/ccc_get_responder.sv
// GET response byte counter and MSB-first byte selector
`timescale 1ns/10ps
`include "ccc_consts.svh"

module ccc_get_responder (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  ccc_pkg::ccc_code_t code_i,
  input  logic               load_i,
  input  logic               next_i,
  input  ccc_pkg::ccc_byte_t get_bcr_i,
  input  ccc_pkg::ccc_byte_t get_dcr_i,
  input  logic [15:0]        get_mwl_i,
  input  logic [47:0]        get_pid_i,
  output ccc_pkg::ccc_byte_t byte_o,
  output logic               last_o
);
  import ccc_pkg::*;

  get_cnt_t        cnt_q;
  get_cnt_t        get_len;
  get_cnt_t        byte_idx;
  ccc_byte_t [1:0] mwl_bytes;
  ccc_byte_t [5:0] pid_bytes;

  assign mwl_bytes = get_mwl_i;
  assign pid_bytes = get_pid_i;
  // Highest byte goes out first
  assign byte_idx  = cnt_q - 3'd1;

  always_comb begin
    case (code_i)
      `CCC_DIRECT_GETBCR, `CCC_DIRECT_GETDCR: get_len = `GET_LEN_BCR;
      `CCC_DIRECT_GETMWL:                     get_len = `GET_LEN_MWL;
      `CCC_DIRECT_GETPID:                     get_len = `GET_LEN_PID;
      default:                                get_len = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= get_len;
    end else if (next_i && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 3'd1;
    end
  end

  always_comb begin
    byte_o = '0;
    if ((cnt_q != '0) && (cnt_q <= get_len)) begin
      case (code_i)
        `CCC_DIRECT_GETBCR: byte_o = get_bcr_i;
        `CCC_DIRECT_GETDCR: byte_o = get_dcr_i;
        `CCC_DIRECT_GETMWL: byte_o = mwl_bytes[byte_idx[0]];
        `CCC_DIRECT_GETPID: byte_o = pid_bytes[byte_idx];
        default:            byte_o = '0;
      endcase
    end
  end

  assign last_o = (cnt_q == 3'd1);

endmodule

//--- design/ccc_set_handler.sv
// SET payload decoding into registered configuration outputs
`timescale 1ns/10ps
`include "ccc_consts.svh"

module ccc_set_handler (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  ccc_pkg::ccc_rx_evt_t rx_evt_i,
  output ccc_pkg::ccc_cfg_t    cfg_o
);
  import ccc_pkg::*;

  logic [1:0] byte_cnt_q;
  ccc_cfg_t   cfg_q;
  logic       is_mwl;
  logic       is_mrl;
  logic       is_enec;
  logic       is_disec;
  logic       hi_byte;
  logic       lo_byte;
  logic [2:0] ec_bits;

  assign is_mwl   = rx_evt_i.code inside {`CCC_BCAST_SETMWL, `CCC_DIRECT_SETMWL};
  assign is_mrl   = rx_evt_i.code inside {`CCC_BCAST_SETMRL, `CCC_DIRECT_SETMRL};
  assign is_enec  = rx_evt_i.code inside {`CCC_BCAST_ENEC, `CCC_DIRECT_ENEC};
  assign is_disec = rx_evt_i.code inside {`CCC_BCAST_DISEC, `CCC_DIRECT_DISEC};

  // Byte 0 is the high byte of a 16-bit length
  assign hi_byte  = rx_evt_i.data_valid && (byte_cnt_q == 2'd0);
  assign lo_byte  = rx_evt_i.data_valid && (byte_cnt_q == 2'd1);
  assign ec_bits  = {rx_evt_i.data[`EC_HJ_BIT], rx_evt_i.data[`EC_CRR_BIT],
                     rx_evt_i.data[`EC_IBI_BIT]};

  // Saturates, only the first two bytes matter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_cnt_q <= '0;
    end else if (rx_evt_i.frame_start) begin
      byte_cnt_q <= '0;
    end else if (rx_evt_i.data_valid && (byte_cnt_q != 2'd3)) begin
      byte_cnt_q <= byte_cnt_q + 2'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else begin
      // Strobes last one cycle
      cfg_q.set_mwl <= is_mwl && lo_byte;
      cfg_q.set_mrl <= is_mrl && lo_byte;
      cfg_q.rstdaa  <= rx_evt_i.cmd_tbit && (rx_evt_i.code == `CCC_BCAST_RSTDAA);
      if (is_mwl && hi_byte) cfg_q.mwl[15:8] <= rx_evt_i.data;
      if (is_mwl && lo_byte) cfg_q.mwl[7:0] <= rx_evt_i.data;
      if (is_mrl && hi_byte) cfg_q.mrl[15:8] <= rx_evt_i.data;
      if (is_mrl && lo_byte) cfg_q.mrl[7:0] <= rx_evt_i.data;
      if (is_enec && hi_byte) cfg_q.enec <= ec_bits;
      if (is_disec && hi_byte) cfg_q.disec <= ec_bits;
    end
  end

  assign cfg_o = cfg_q;

endmodule

//--- design/ccc_top.sv
// CCC handler top level joining sequencer, GET responder and SET handler
`timescale 1ns/10ps

module ccc_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  ccc_pkg::ccc_code_t       ccc_i,
  input  logic                     ccc_valid_i,
  input  ccc_bus_pkg::bus_evt_t    bus_evt_i,
  input  ccc_bus_pkg::bus_rx_rsp_t bus_rx_i,
  input  logic                     bus_tx_done_i,
  input  ccc_pkg::target_addr_t    target_addr_i,
  input  ccc_pkg::ccc_byte_t       get_bcr_i,
  input  ccc_pkg::ccc_byte_t       get_dcr_i,
  input  logic [15:0]              get_mwl_i,
  input  logic [47:0]              get_pid_i,
  output ccc_bus_pkg::bus_rx_req_t bus_rx_req_o,
  output ccc_bus_pkg::bus_tx_req_t bus_tx_req_o,
  output logic                     done_o,
  output logic                     next_ccc_o,
  output ccc_pkg::ccc_cfg_t        cfg_o
);
  import ccc_pkg::*;

  ccc_code_t   ccc_code;
  ccc_byte_t   get_byte;
  logic        get_last;
  logic        get_load;
  logic        get_next;
  ccc_rx_evt_t rx_evt;

  ccc_sequencer u_sequencer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ccc_i         (ccc_i),
    .ccc_valid_i   (ccc_valid_i),
    .bus_evt_i     (bus_evt_i),
    .bus_rx_i      (bus_rx_i),
    .bus_tx_done_i (bus_tx_done_i),
    .target_addr_i (target_addr_i),
    .get_byte_i    (get_byte),
    .get_last_i    (get_last),
    .bus_rx_req_o  (bus_rx_req_o),
    .bus_tx_req_o  (bus_tx_req_o),
    .get_load_o    (get_load),
    .get_next_o    (get_next),
    .ccc_code_o    (ccc_code),
    .rx_evt_o      (rx_evt),
    .done_o        (done_o),
    .next_ccc_o    (next_ccc_o)
  );

  ccc_get_responder u_get_responder (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .code_i    (ccc_code),
    .load_i    (get_load),
    .next_i    (get_next),
    .get_bcr_i (get_bcr_i),
    .get_dcr_i (get_dcr_i),
    .get_mwl_i (get_mwl_i),
    .get_pid_i (get_pid_i),
    .byte_o    (get_byte),
    .last_o    (get_last)
  );

  ccc_set_handler u_set_handler (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .rx_evt_i (rx_evt),
    .cfg_o    (cfg_o)
  );

endmodule

//--- verif/ccc_assert.sv
// Bound checks for bus requests, SET outputs, GET responses, address ACK and stop handling
`timescale 1ns/10ps
`include "ccc_consts.svh"

module ccc_assert (
  input logic                     clk_i,
  input logic                     rst_ni,
  input ccc_pkg::ccc_code_t       ccc_i,
  input logic                     ccc_valid_i,
  input ccc_bus_pkg::bus_evt_t    bus_evt_i,
  input ccc_bus_pkg::bus_rx_rsp_t bus_rx_i,
  input logic                     bus_tx_done_i,
  input ccc_pkg::target_addr_t    target_addr_i,
  input ccc_pkg::ccc_byte_t       get_bcr_i,
  input ccc_pkg::ccc_byte_t       get_dcr_i,
  input logic [15:0]              get_mwl_i,
  input logic [47:0]              get_pid_i,
  input ccc_bus_pkg::bus_rx_req_t bus_rx_req_o,
  input ccc_bus_pkg::bus_tx_req_t bus_tx_req_o,
  input logic                     done_o,
  input logic                     next_ccc_o,
  input ccc_pkg::ccc_cfg_t        cfg_o
);
  import ccc_pkg::*;

  int unsigned err_cnt = 0;
  ccc_code_t   code_q;
  ccc_byte_t   b0_q;
  ccc_byte_t   b1_q;
  i3c_addr_t   addr_q;
  logic        addr_next_q;
  logic        started_q;
  logic        after_byte_q;
  logic        nacked_q;
  logic [2:0]  rx_cnt_q;
  logic [2:0]  tx_idx_q;
  logic        rx_bit_done;
  logic        rx_byte_done;
  logic        tx_bit_done;
  logic        tx_byte_done;
  logic        any_req;
  logic        exp_ack;
  logic [2:0]  exp_len;
  ccc_byte_t   exp_byte;

  function automatic logic [2:0] event_bits(input ccc_byte_t b);
    return {b[`EC_HJ_BIT], b[`EC_CRR_BIT], b[`EC_IBI_BIT]};
  endfunction

  assign rx_bit_done  = bus_rx_req_o.req_bit && bus_rx_i.done;
  assign rx_byte_done = bus_rx_req_o.req_byte && bus_rx_i.done;
  assign tx_bit_done  = bus_tx_req_o.req_bit && bus_tx_done_i;
  assign tx_byte_done = bus_tx_req_o.req_byte && bus_tx_done_i;
  assign any_req      = |{bus_rx_req_o.req_bit, bus_rx_req_o.req_byte,
                          bus_tx_req_o.req_bit, bus_tx_req_o.req_byte};
  assign exp_ack      = (addr_q == `I3C_RSVD_ADDR) ||
                        (target_addr_i.sta_valid && (addr_q == target_addr_i.sta_addr)) ||
                        (target_addr_i.dyn_valid && (addr_q == target_addr_i.dyn_addr));

  // Expected GET byte with the most significant byte first
  always_comb begin
    exp_len  = 3'd0;
    exp_byte = 8'h00;
    case (code_q)
      `CCC_DIRECT_GETBCR: begin
        exp_len  = `GET_LEN_BCR;
        exp_byte = get_bcr_i;
      end
      `CCC_DIRECT_GETDCR: begin
        exp_len  = `GET_LEN_BCR;
        exp_byte = get_dcr_i;
      end
      `CCC_DIRECT_GETMWL: begin
        exp_len  = `GET_LEN_MWL;
        exp_byte = get_mwl_i[15 - 8*tx_idx_q -: 8];
      end
      `CCC_DIRECT_GETPID: begin
        exp_len  = `GET_LEN_PID;
        exp_byte = get_pid_i[47 - 8*tx_idx_q -: 8];
      end
      default: begin
      end
    endcase
  end

  // Record of the current frame as seen on the bus
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      code_q       <= '0;
      b0_q         <= '0;
      b1_q         <= '0;
      addr_q       <= '0;
      addr_next_q  <= 1'b0;
      started_q    <= 1'b0;
      after_byte_q <= 1'b0;
      nacked_q     <= 1'b0;
      rx_cnt_q     <= '0;
      tx_idx_q     <= '0;
    end else begin
      if (ccc_valid_i) begin
        code_q       <= ccc_i;
        started_q    <= 1'b1;
        rx_cnt_q     <= '0;
        tx_idx_q     <= '0;
        after_byte_q <= 1'b0;
        nacked_q     <= 1'b0;
      end
      if (bus_evt_i.rstart_det) begin
        addr_next_q <= 1'b1;
        nacked_q    <= 1'b0;
      end
      if (rx_byte_done) begin
        b1_q     <= b0_q;
        b0_q     <= bus_rx_i.data;
        rx_cnt_q <= rx_cnt_q + 3'd1;
        // First byte after a repeated start is the address
        if (addr_next_q) begin
          addr_q      <= bus_rx_i.data[7:1];
          addr_next_q <= 1'b0;
        end
      end
      if (tx_byte_done) begin
        tx_idx_q     <= tx_idx_q + 3'd1;
        after_byte_q <= 1'b1;
      end
      if (tx_bit_done) begin
        after_byte_q <= 1'b0;
        if (!after_byte_q && bus_tx_req_o.value[0]) begin
          nacked_q <= 1'b1;
        end
      end
    end
  end

  a_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !started_q |-> !any_req && !done_o && !next_ccc_o && (cfg_o == '0))
    else begin
      err_cnt++;
      $error("Outputs became active before the first CCC was issued");
    end

  a_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({bus_rx_req_o.req_bit, bus_rx_req_o.req_byte,
              bus_tx_req_o.req_bit, bus_tx_req_o.req_byte}))
    else begin
      err_cnt++;
      $error("More than one bus request was raised at the same time");
    end

  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (any_req && !bus_rx_i.done && !bus_tx_done_i && (bus_evt_i == '0)) |=>
      $stable(bus_rx_req_o) && $stable(bus_tx_req_o))
    else begin
      err_cnt++;
      $error("A bus request changed while its done was still pending");
    end

  a_mwl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((code_q == `CCC_BCAST_SETMWL) && rx_bit_done && (rx_cnt_q == 3'd2)) |=>
      cfg_o.set_mwl && (cfg_o.mwl == {b1_q, b0_q}))
    else begin
      err_cnt++;
      $error("ERROR %0t set_mwl/mwl got %b/%h expected 1/%h", $time,
             $sampled(cfg_o.set_mwl), $sampled(cfg_o.mwl), $sampled({b1_q, b0_q}));
    end

  a_mrl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((code_q == `CCC_BCAST_SETMRL) && rx_bit_done && (rx_cnt_q == 3'd2)) |=>
      cfg_o.set_mrl && (cfg_o.mrl == {b1_q, b0_q}))
    else begin
      err_cnt++;
      $error("ERROR %0t set_mrl/mrl got %b/%h expected 1/%h", $time,
             $sampled(cfg_o.set_mrl), $sampled(cfg_o.mrl), $sampled({b1_q, b0_q}));
    end

  a_enec: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((code_q == `CCC_BCAST_ENEC) && rx_bit_done && (rx_cnt_q == 3'd1)) |=>
      (cfg_o.enec == event_bits(b0_q)))
    else begin
      err_cnt++;
      $error("ERROR %0t enec got %b expected %b", $time,
             $sampled(cfg_o.enec), event_bits($sampled(b0_q)));
    end

  a_disec: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((code_q == `CCC_BCAST_DISEC) && rx_bit_done && (rx_cnt_q == 3'd1)) |=>
      (cfg_o.disec == event_bits(b0_q)))
    else begin
      err_cnt++;
      $error("ERROR %0t disec got %b expected %b", $time,
             $sampled(cfg_o.disec), event_bits($sampled(b0_q)));
    end

  a_rstdaa: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((code_q == `CCC_BCAST_RSTDAA) && rx_bit_done && (rx_cnt_q == 3'd0)) |=> cfg_o.rstdaa)
    else begin
      err_cnt++;
      $error("RSTDAA did not raise the rstdaa strobe after its T-bit");
    end

  // Strobes last exactly one cycle
  a_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cfg_o.set_mwl || cfg_o.set_mrl || cfg_o.rstdaa) |=>
      !(cfg_o.set_mwl || cfg_o.set_mrl || cfg_o.rstdaa))
    else begin
      err_cnt++;
      $error("A configuration strobe stayed high for more than one cycle");
    end

  a_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bus_tx_req_o.req_bit && !after_byte_q) |-> (bus_tx_req_o.value[0] == !exp_ack))
    else begin
      err_cnt++;
      $error("ERROR %0t ACK bus_tx_req_o.value[0] got %b expected %b", $time,
             $sampled(bus_tx_req_o.value[0]), !$sampled(exp_ack));
    end

  a_tx_byte: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_tx_req_o.req_byte |-> (bus_tx_req_o.value == exp_byte))
    else begin
      err_cnt++;
      $error("ERROR %0t GET byte bus_tx_req_o.value got %h expected %h", $time,
             $sampled(bus_tx_req_o.value), $sampled(exp_byte));
    end

  a_tbit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bus_tx_req_o.req_bit && after_byte_q) |->
      (bus_tx_req_o.value[0] == (tx_idx_q < exp_len)))
    else begin
      err_cnt++;
      $error("ERROR %0t T-bit bus_tx_req_o.value[0] got %b expected %b", $time,
             $sampled(bus_tx_req_o.value[0]), $sampled(tx_idx_q < exp_len));
    end

  // ACK is open drain while read data and T-bits are push-pull
  a_drive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bus_tx_req_o.req_bit || bus_tx_req_o.req_byte) |->
      (bus_tx_req_o.sel_od_pp == (bus_tx_req_o.req_byte || after_byte_q)))
    else begin
      err_cnt++;
      $error("ERROR %0t bus_tx_req_o.sel_od_pp got %b expected %b", $time,
             $sampled(bus_tx_req_o.sel_od_pp),
             $sampled(bus_tx_req_o.req_byte || after_byte_q));
    end

  a_nack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    nacked_q |-> !bus_tx_req_o.req_byte)
    else begin
      err_cnt++;
      $error("A byte was sent after the address was not acknowledged");
    end

  a_rsvd: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (tx_bit_done && !after_byte_q && (addr_q == `I3C_RSVD_ADDR)) |=>
      next_ccc_o ##1 !next_ccc_o)
    else begin
      err_cnt++;
      $error("next_ccc_o did not pulse once after the reserved address");
    end

  a_stop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_evt_i.stop_det |=> (done_o && !any_req) ##1 !done_o)
    else begin
      err_cnt++;
      $error("done_o did not follow the stop as a single pulse without requests");
    end

endmodule

//--- verif/ccc_tb.sv
// Testbench with clock, reset, bus engine model, CCC scenarios, watchdog and final report
`timescale 1ns/10ps
`include "ccc_consts.svh"

module ccc_tb;
  import ccc_pkg::*;
  import ccc_bus_pkg::*;

  // About 11 CCCs of at most 25 bus steps with up to 4 cycles each and a wide margin
  localparam int unsigned MAX_CYCLES = 3000;

  logic         clk_i;
  logic         rst_ni;
  ccc_code_t    ccc_i;
  logic         ccc_valid_i;
  bus_evt_t     bus_evt_i;
  bus_rx_rsp_t  bus_rx_i;
  logic         bus_tx_done_i;
  target_addr_t target_addr_i;
  ccc_byte_t    get_bcr_i;
  ccc_byte_t    get_dcr_i;
  logic [15:0]  get_mwl_i;
  logic [47:0]  get_pid_i;
  bus_rx_req_t  bus_rx_req_o;
  bus_tx_req_t  bus_tx_req_o;
  logic         done_o;
  logic         next_ccc_o;
  ccc_cfg_t     cfg_o;

  integer       data_seed;
  integer       delay_seed;
  // Bit 8 set marks a repeated start instead of a data byte
  logic [8:0]   rx_script[$];
  logic         busy;
  logic         pulse_q;
  logic [1:0]   delay;
  int unsigned  cycles;
  int unsigned  timeouts;

  ccc_top uut (.*);

  bind ccc_top ccc_assert u_assert (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Bus engine model answering each request after 0 to 3 idle cycles
  always @(posedge clk_i) begin
    bus_rx_i      <= '0;
    bus_tx_done_i <= 1'b0;
    bus_evt_i     <= '0;
    if (!rst_ni) begin
      busy    <= 1'b0;
      pulse_q <= 1'b0;
      delay   <= 2'd0;
    end else begin
      if (ccc_valid_i) busy <= 1'b1;
      if (done_o || next_ccc_o) busy <= 1'b0;
      if (pulse_q) begin
        // DUT takes the response in this cycle
        pulse_q <= 1'b0;
        delay   <= 2'($random(delay_seed) & 3);
      end else if (delay != 2'd0) begin
        delay <= delay - 2'd1;
      end else if (bus_rx_req_o.req_bit) begin
        bus_rx_i.done <= 1'b1;
        pulse_q       <= 1'b1;
      end else if (bus_tx_req_o.req_bit || bus_tx_req_o.req_byte) begin
        bus_tx_done_i <= 1'b1;
        pulse_q       <= 1'b1;
      end else if (bus_rx_req_o.req_byte && (rx_script.size() != 0)) begin
        if (rx_script[0][8]) begin
          bus_evt_i.rstart_det <= 1'b1;
        end else begin
          bus_rx_i.done <= 1'b1;
          bus_rx_i.data <= rx_script[0][7:0];
        end
        void'(rx_script.pop_front());
        pulse_q <= 1'b1;
      end else if (busy && !done_o && !next_ccc_o) begin
        // Controller closes the frame once the script is used up
        bus_evt_i.stop_det <= 1'b1;
        pulse_q            <= 1'b1;
      end
    end
  end

  task automatic finish_run();
    int unsigned errs;
    errs = uut.u_assert.err_cnt;
    $display("Assertion errors: %0d, timeouts: %0d", errs, timeouts);
    if ((errs == 0) && (timeouts == 0)) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: the CCC sequence did not finish within %0d cycles", MAX_CYCLES);
      timeouts = timeouts + 1;
      finish_run();
    end
  end

  task automatic push_data(input int n);
    repeat (n) rx_script.push_back({1'b0, 8'($random(data_seed))});
  endtask

  // Issue one CCC and wait for its end or the hand over
  task automatic run_ccc(input ccc_code_t code);
    ccc_i       <= code;
    ccc_valid_i <= 1'b1;
    @(posedge clk_i);
    ccc_valid_i <= 1'b0;
    do @(posedge clk_i); while (!(done_o || next_ccc_o));
    @(posedge clk_i);
  endtask

  task automatic addressed_ccc(input ccc_code_t code, input i3c_addr_t addr, input logic rnw);
    rx_script.push_back(9'h100);
    rx_script.push_back({1'b0, addr, rnw});
    run_ccc(code);
  endtask

  initial begin
    data_seed     = 32'h4ca1;
    delay_seed    = 32'h4ca1;
    cycles        = 0;
    timeouts      = 0;
    rst_ni        = 1'b0;
    ccc_i         = '0;
    ccc_valid_i   = 1'b0;
    bus_evt_i     = '0;
    bus_rx_i      = '0;
    bus_tx_done_i = 1'b0;
    target_addr_i = {7'h21, 1'b1, 7'h35, 1'b1};
    get_bcr_i     = 8'h66;
    get_dcr_i     = 8'hc4;
    get_mwl_i     = 16'h01f3;
    get_pid_i     = 48'h5a17_3c92_e04b;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    push_data(2);
    run_ccc(`CCC_BCAST_SETMWL);
    push_data(2);
    run_ccc(`CCC_BCAST_SETMRL);
    push_data(1);
    run_ccc(`CCC_BCAST_ENEC);
    push_data(1);
    run_ccc(`CCC_BCAST_DISEC);
    run_ccc(`CCC_BCAST_RSTDAA);
    addressed_ccc(`CCC_DIRECT_GETPID, 7'h35, 1'b1);
    addressed_ccc(`CCC_DIRECT_GETMWL, 7'h35, 1'b1);
    addressed_ccc(`CCC_DIRECT_GETBCR, 7'h21, 1'b1);
    addressed_ccc(`CCC_DIRECT_GETDCR, 7'h35, 1'b1);
    // Foreign address followed by the reserved one
    addressed_ccc(`CCC_DIRECT_GETBCR, 7'h44, 1'b1);
    addressed_ccc(`CCC_DIRECT_ENEC, `I3C_RSVD_ADDR, 1'b0);
    @(negedge clk_i);
    finish_run();
  end

endmodule

//--- all.f
+incdir+design
design/ccc_pkg.sv
design/ccc_bus_pkg.sv
design/ccc_sequencer.sv
design/ccc_get_responder.sv
design/ccc_set_handler.sv
design/ccc_top.sv
verif/ccc_assert.sv
verif/ccc_tb.sv
